/* src/vic_pkg.sv */
package vic_pkg;

    // palette index, one of 16 colours
    typedef logic [3:0] color_t;

    // one fetched byte of pixel data
    typedef logic [7:0] gfx_byte_t;

    // colour ram nibble in 11..8, character or bitmap code in 7..0
    typedef logic [11:0] char_code_t;

    typedef logic [2:0] xscroll_t;

    // bus cycle within a raster line
    typedef logic [6:0] cycle_t;

    // {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        mode_std_char        = 3'b000,
        mode_mc_char         = 3'b001,
        mode_std_bmp         = 3'b010,
        mode_mc_bmp          = 3'b011,
        mode_ecm_char        = 3'b100,
        mode_inv_ecm_mc_char = 3'b101,
        mode_inv_ecm_bmp     = 3'b110,
        mode_inv_ecm_mc_bmp  = 3'b111
    } vic_mode_e;

    localparam int NUM_SPRITES = 8;

    // dot4x clocks per bus cycle, four per dot
    localparam int PHASES_PER_CYCLE  = 32;
    localparam int PIXEL_LATCH_PHASE = 12;
    localparam int XSCROLL_PHASE     = 15;

    localparam int CYCLES_PER_LINE = 63;
    localparam int VISIBLE_FIRST   = 15;
    localparam int VISIBLE_LAST    = 55;

    localparam color_t COLOR_BLACK = 4'h0;

endpackage

/* src/dot_timing.sv */
`timescale 1ns/1ps

module dot_timing (
    input  logic            clk_dot4x,
    input  logic            rst,
    output logic            dot_strobe_o,
    output logic            latch_strobe_o,
    output logic            scroll_strobe_o,
    output logic [2:0]      dot_pos_o,
    output vic_pkg::cycle_t cycle_num_o
);

    logic [4:0] phase;
    logic [4:0] phase_next;
    logic       phase_wrap;

    assign phase_wrap = (phase == 5'(vic_pkg::PHASES_PER_CYCLE - 1));
    assign phase_next = phase_wrap ? 5'd0 : phase + 5'd1;

    // strobes decoded from the next phase so they line up with the phase register
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase           <= '0;
            dot_strobe_o    <= 1'b0;
            latch_strobe_o  <= 1'b0;
            scroll_strobe_o <= 1'b0;
            dot_pos_o       <= '0;
        end else begin
            phase           <= phase_next;
            dot_strobe_o    <= (phase_next[1:0] == 2'b00);
            latch_strobe_o  <= (phase_next == 5'(vic_pkg::PIXEL_LATCH_PHASE));
            scroll_strobe_o <= (phase_next == 5'(vic_pkg::XSCROLL_PHASE));
            dot_pos_o       <= phase_next[4:2];
        end
    end

    // bus cycle within the line
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle_num_o <= '0;
        end else if (phase_wrap) begin
            if (cycle_num_o == vic_pkg::cycle_t'(vic_pkg::CYCLES_PER_LINE - 1)) begin
                cycle_num_o <= '0;
            end else begin
                cycle_num_o <= cycle_num_o + 7'd1;
            end
        end
    end

    // fetch strobes belong to the low bus phase
    a_strobes_low_phase: assert property (@(posedge clk_dot4x) disable iff (rst)
        (latch_strobe_o || scroll_strobe_o) |-> !phase[4]);

endmodule

/* src/gfx_latch.sv */
`timescale 1ns/1ps

module gfx_latch (
    input  logic                clk_dot4x,
    input  logic                rst,
    input  logic                latch_strobe_i,
    input  logic                scroll_strobe_i,
    input  vic_pkg::cycle_t     cycle_num_i,
    input  vic_pkg::gfx_byte_t  pixels_read_i,
    input  vic_pkg::char_code_t char_read_i,
    input  vic_pkg::xscroll_t   xscroll_i,
    output vic_pkg::gfx_byte_t  pixels_o,
    output vic_pkg::char_code_t char_o,
    output vic_pkg::xscroll_t   xscroll_o
);

    logic in_window;

    assign in_window = (cycle_num_i >= vic_pkg::cycle_t'(vic_pkg::VISIBLE_FIRST)) &&
                       (cycle_num_i <= vic_pkg::cycle_t'(vic_pkg::VISIBLE_LAST));

    // byte and code held until the next fetch lands
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_o <= '0;
            char_o   <= '0;
        end else if (latch_strobe_i) begin
            pixels_o <= pixels_read_i;
            char_o   <= char_read_i;
        end
    end

    // fine scroll only follows the register inside visible cycles
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_o <= '0;
        end else if (scroll_strobe_i && in_window) begin
            xscroll_o <= xscroll_i;
        end
    end

endmodule

/* src/pixel_shifter.sv */
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                clk_dot4x,
    input  logic                rst,
    input  logic                dot_strobe_i,
    input  logic [2:0]          dot_pos_i,
    input  vic_pkg::vic_mode_e  mode_i,
    input  vic_pkg::gfx_byte_t  pixels_i,
    input  vic_pkg::char_code_t char_i,
    input  vic_pkg::xscroll_t   xscroll_i,
    output logic [1:0]          gfx_bits_o,
    output vic_pkg::char_code_t char_o,
    output logic                is_background_o
);

    vic_pkg::gfx_byte_t  shift_q;
    vic_pkg::char_code_t char_q;
    logic                mc_q;
    logic                pair_q;
    logic                load;
    logic                mc_load;

    assign load = (dot_pos_i == xscroll_i);

    // multicolour needs mcm plus bitmap, ecm or colour nibble bit 3
    assign mc_load = mode_i[0] & (mode_i[1] | mode_i[2] | char_i[11]);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_q         <= '0;
            char_q          <= '0;
            mc_q            <= 1'b0;
            pair_q          <= 1'b0;
            is_background_o <= 1'b1;
        end else if (dot_strobe_i) begin
            if (load) begin
                shift_q         <= pixels_i;
                char_q          <= char_i;
                mc_q            <= mc_load;
                // multicolour holds the first pair for an extra dot
                pair_q          <= ~mc_load;
                is_background_o <= ~pixels_i[7];
            end else begin
                if (pair_q) begin
                    if (mc_q) begin
                        shift_q         <= {shift_q[5:0], 2'b00};
                        is_background_o <= ~shift_q[5];
                    end else begin
                        shift_q         <= {shift_q[6:0], 1'b0};
                        is_background_o <= ~shift_q[6];
                    end
                end
                if (mc_q) begin
                    pair_q <= ~pair_q;
                end
            end
        end
    end

    assign gfx_bits_o = shift_q[7:6];
    assign char_o     = char_q;

    // pixel data only moves on dot boundaries
    a_shift_on_dot: assert property (@(posedge clk_dot4x) disable iff (rst)
        !dot_strobe_i |=> $stable(shift_q));

endmodule

/* src/color_mixer.sv */
`timescale 1ns/1ps

module color_mixer (
    input  logic                                   clk_dot4x,
    input  logic                                   rst,
    input  logic                                   dot_strobe_i,
    input  vic_pkg::vic_mode_e                     mode_i,
    input  logic [1:0]                             gfx_bits_i,
    input  vic_pkg::char_code_t                    char_i,
    input  logic                                   is_background_i,
    input  vic_pkg::color_t                        b0c_i,
    input  vic_pkg::color_t                        b1c_i,
    input  vic_pkg::color_t                        b2c_i,
    input  vic_pkg::color_t                        b3c_i,
    input  vic_pkg::color_t                        ec_i,
    input  logic                                   main_border_i,
    input  logic [2*vic_pkg::NUM_SPRITES-1:0]      sprite_pixels_i,
    input  logic [4*vic_pkg::NUM_SPRITES-1:0]      sprite_colors_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]        sprite_pri_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]        sprite_mmc_i,
    input  vic_pkg::color_t                        sprite_mc0_i,
    input  vic_pkg::color_t                        sprite_mc1_i,
    output vic_pkg::color_t                        pixel_color_o
);

    logic [2*vic_pkg::NUM_SPRITES-1:0] spr_pix_q;
    logic [1:0]                        spr_pix [vic_pkg::NUM_SPRITES];
    vic_pkg::color_t                   spr_col [vic_pkg::NUM_SPRITES];
    vic_pkg::color_t                   mc_char_color;
    vic_pkg::color_t                   mc_bmp_color;
    vic_pkg::color_t                   ecm_color;
    vic_pkg::color_t                   color1_dec;
    vic_pkg::color_t                   color1_q;
    vic_pkg::color_t                   base_color;
    vic_pkg::color_t                   color2_next;
    vic_pkg::color_t                   color2_q;
    logic                              bg_q;
    logic                              invalid_mode;

    // sprite 0 sits in the top bits
    always_comb begin
        for (int n = 0; n < vic_pkg::NUM_SPRITES; n++) begin
            spr_pix[n] = spr_pix_q[2*(vic_pkg::NUM_SPRITES-1-n) +: 2];
            spr_col[n] = sprite_colors_i[4*(vic_pkg::NUM_SPRITES-1-n) +: 4];
        end
    end

    // stage 1, mode decode
    always_comb begin
        case (gfx_bits_i)
            2'b00:   mc_char_color = b0c_i;
            2'b01:   mc_char_color = b1c_i;
            2'b10:   mc_char_color = b2c_i;
            default: mc_char_color = {1'b0, char_i[10:8]};
        endcase
        case (gfx_bits_i)
            2'b00:   mc_bmp_color = b0c_i;
            2'b01:   mc_bmp_color = char_i[7:4];
            2'b10:   mc_bmp_color = char_i[3:0];
            default: mc_bmp_color = char_i[11:8];
        endcase
        // background register picked by the top two code bits
        if (gfx_bits_i[1]) begin
            ecm_color = char_i[11:8];
        end else begin
            case (char_i[7:6])
                2'b00:   ecm_color = b0c_i;
                2'b01:   ecm_color = b1c_i;
                2'b10:   ecm_color = b2c_i;
                default: ecm_color = b3c_i;
            endcase
        end
        case (mode_i)
            vic_pkg::mode_std_char:
                color1_dec = gfx_bits_i[1] ? char_i[11:8] : b0c_i;
            vic_pkg::mode_mc_char:
                color1_dec = char_i[11] ? mc_char_color : (gfx_bits_i[1] ? char_i[11:8] : b0c_i);
            vic_pkg::mode_std_bmp, vic_pkg::mode_inv_ecm_bmp:
                color1_dec = gfx_bits_i[1] ? char_i[7:4] : char_i[3:0];
            vic_pkg::mode_mc_bmp, vic_pkg::mode_inv_ecm_mc_bmp:
                color1_dec = mc_bmp_color;
            vic_pkg::mode_ecm_char:
                color1_dec = ecm_color;
            default:
                color1_dec = char_i[11] ? mc_char_color : ecm_color;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color1_q  <= vic_pkg::COLOR_BLACK;
            bg_q      <= 1'b1;
            spr_pix_q <= '0;
        end else if (dot_strobe_i) begin
            color1_q  <= color1_dec;
            bg_q      <= is_background_i;
            spr_pix_q <= sprite_pixels_i;
        end
    end

    // stage 2, invalid modes go black, then the sprite overlay
    assign invalid_mode = mode_i inside {vic_pkg::mode_inv_ecm_mc_char,
                                         vic_pkg::mode_inv_ecm_bmp,
                                         vic_pkg::mode_inv_ecm_mc_bmp};
    assign base_color = invalid_mode ? vic_pkg::COLOR_BLACK : color1_q;

    always_comb begin
        color2_next = base_color;
        // lowest numbered sprite is applied last and wins
        for (int n = vic_pkg::NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprite_pri_i[n] || bg_q) begin
                if (sprite_mmc_i[n]) begin
                    if (spr_pix[n] == 2'b01) begin
                        color2_next = sprite_mc0_i;
                    end else if (spr_pix[n] == 2'b10) begin
                        color2_next = spr_col[n];
                    end else if (spr_pix[n] == 2'b11) begin
                        color2_next = sprite_mc1_i;
                    end
                end else if (spr_pix[n][1]) begin
                    color2_next = spr_col[n];
                end
            end
            // a behind-foreground sprite undoes what a lower sprite drew over foreground
            if (sprite_pri_i[n] && !bg_q && spr_pix[n][1]) begin
                color2_next = base_color;
            end
        end
    end

    // stage 2 and stage 3 (border mask)
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color2_q      <= vic_pkg::COLOR_BLACK;
            pixel_color_o <= vic_pkg::COLOR_BLACK;
        end else begin
            color2_q      <= color2_next;
            pixel_color_o <= main_border_i ? ec_i : color2_q;
        end
    end

    a_border_wins: assert property (@(posedge clk_dot4x) disable iff (rst)
        main_border_i |=> (pixel_color_o == $past(ec_i)));

endmodule

/* src/pixel_path_top.sv */
`timescale 1ns/1ps

module pixel_path_top (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  vic_pkg::gfx_byte_t                 pixels_read_i,
    input  vic_pkg::char_code_t                char_read_i,
    input  vic_pkg::xscroll_t                  xscroll_i,
    input  logic                               ecm_i,
    input  logic                               bmm_i,
    input  logic                               mcm_i,
    input  vic_pkg::color_t                    b0c_i,
    input  vic_pkg::color_t                    b1c_i,
    input  vic_pkg::color_t                    b2c_i,
    input  vic_pkg::color_t                    b3c_i,
    input  vic_pkg::color_t                    ec_i,
    input  logic                               main_border_i,
    input  logic [2*vic_pkg::NUM_SPRITES-1:0]  sprite_pixels_i,
    input  logic [4*vic_pkg::NUM_SPRITES-1:0]  sprite_colors_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]    sprite_pri_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]    sprite_mmc_i,
    input  vic_pkg::color_t                    sprite_mc0_i,
    input  vic_pkg::color_t                    sprite_mc1_i,
    output vic_pkg::color_t                    pixel_color_o,
    output logic                               is_background_o
);

    logic                dot_strobe;
    logic                latch_strobe;
    logic                scroll_strobe;
    logic [2:0]          dot_pos;
    vic_pkg::cycle_t     cycle_num;
    vic_pkg::gfx_byte_t  latched_pixels;
    vic_pkg::char_code_t latched_char;
    vic_pkg::xscroll_t   latched_xscroll;
    logic [1:0]          gfx_bits;
    vic_pkg::char_code_t shift_char;
    logic                is_background;
    vic_pkg::vic_mode_e  mode;

    assign mode = vic_pkg::vic_mode_e'({ecm_i, bmm_i, mcm_i});

    dot_timing timing_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_strobe_o    (dot_strobe),
        .latch_strobe_o  (latch_strobe),
        .scroll_strobe_o (scroll_strobe),
        .dot_pos_o       (dot_pos),
        .cycle_num_o     (cycle_num)
    );

    gfx_latch latch_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .latch_strobe_i  (latch_strobe),
        .scroll_strobe_i (scroll_strobe),
        .cycle_num_i     (cycle_num),
        .pixels_read_i   (pixels_read_i),
        .char_read_i     (char_read_i),
        .xscroll_i       (xscroll_i),
        .pixels_o        (latched_pixels),
        .char_o          (latched_char),
        .xscroll_o       (latched_xscroll)
    );

    pixel_shifter shifter_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_strobe_i    (dot_strobe),
        .dot_pos_i       (dot_pos),
        .mode_i          (mode),
        .pixels_i        (latched_pixels),
        .char_i          (latched_char),
        .xscroll_i       (latched_xscroll),
        .gfx_bits_o      (gfx_bits),
        .char_o          (shift_char),
        .is_background_o (is_background)
    );

    color_mixer mixer_i (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_strobe_i    (dot_strobe),
        .mode_i          (mode),
        .gfx_bits_i      (gfx_bits),
        .char_i          (shift_char),
        .is_background_i (is_background),
        .b0c_i           (b0c_i),
        .b1c_i           (b1c_i),
        .b2c_i           (b2c_i),
        .b3c_i           (b3c_i),
        .ec_i            (ec_i),
        .main_border_i   (main_border_i),
        .sprite_pixels_i (sprite_pixels_i),
        .sprite_colors_i (sprite_colors_i),
        .sprite_pri_i    (sprite_pri_i),
        .sprite_mmc_i    (sprite_mmc_i),
        .sprite_mc0_i    (sprite_mc0_i),
        .sprite_mc1_i    (sprite_mc1_i),
        .pixel_color_o   (pixel_color_o)
    );

    assign is_background_o = is_background;

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 20 ns period
    localparam real HALF_PERIOD = 10.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

/* verification/pixel_ref_model.sv */
`timescale 1ns/1ps

module pixel_ref_model (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  vic_pkg::gfx_byte_t    pixels_read_i,
    input  vic_pkg::char_code_t   char_read_i,
    input  vic_pkg::xscroll_t     xscroll_i,
    input  logic                  ecm_i,
    input  logic                  bmm_i,
    input  logic                  mcm_i,
    input  vic_pkg::color_t       b0c_i,
    input  vic_pkg::color_t       b1c_i,
    input  vic_pkg::color_t       b2c_i,
    input  vic_pkg::color_t       b3c_i,
    input  vic_pkg::color_t       ec_i,
    input  logic                  main_border_i,
    input  logic [15:0]           sprite_pixels_i,
    input  logic [31:0]           sprite_colors_i,
    input  logic [7:0]            sprite_pri_i,
    input  logic [7:0]            sprite_mmc_i,
    input  vic_pkg::color_t       sprite_mc0_i,
    input  vic_pkg::color_t       sprite_mc1_i,
    output logic [4:0]            phase_o,
    output vic_pkg::color_t       exp_color_o,
    output logic                  exp_background_o
);

    logic                running;
    vic_pkg::cycle_t     line_cycle;
    vic_pkg::gfx_byte_t  fetch_byte;
    vic_pkg::char_code_t fetch_code;
    vic_pkg::xscroll_t   fine_x;
    vic_pkg::gfx_byte_t  sr;
    vic_pkg::char_code_t sr_code;
    logic                sr_mc;
    logic                sr_odd;
    vic_pkg::color_t     s1_color;
    logic                s1_bg;
    logic [15:0]         s1_spr;
    vic_pkg::color_t     s2_color;
    logic                dot_now;
    logic                in_window;
    logic                invalid;

    // no dot strobe in the very first clock after reset
    assign dot_now   = running && (phase_o[1:0] == 2'b00);
    assign in_window = (int'(line_cycle) >= vic_pkg::VISIBLE_FIRST) &&
                       (int'(line_cycle) <= vic_pkg::VISIBLE_LAST);
    assign invalid   = ecm_i && (bmm_i || mcm_i);

    // colour for the pixel bits at the top of the shifter
    function automatic vic_pkg::color_t decode_color(logic [1:0] bits,
                                                     vic_pkg::char_code_t code);
        vic_pkg::color_t c;
        vic_pkg::color_t back;
        case (ecm_i ? code[7:6] : 2'b00)
            2'b00:   back = b0c_i;
            2'b01:   back = b1c_i;
            2'b10:   back = b2c_i;
            default: back = b3c_i;
        endcase
        if (bmm_i && !mcm_i) begin
            c = bits[1] ? code[7:4] : code[3:0];
        end else if (bmm_i) begin
            case (bits)
                2'b00:   c = b0c_i;
                2'b01:   c = code[7:4];
                2'b10:   c = code[3:0];
                default: c = code[11:8];
            endcase
        end else if (mcm_i && code[11]) begin
            case (bits)
                2'b00:   c = b0c_i;
                2'b01:   c = b1c_i;
                2'b10:   c = b2c_i;
                default: c = {1'b0, code[10:8]};
            endcase
        end else begin
            c = bits[1] ? code[11:8] : back;
        end
        return c;
    endfunction

    // sprite 7 first, so sprite 0 ends on top
    function automatic vic_pkg::color_t overlay(vic_pkg::color_t base, logic bg,
                                                logic [15:0] pix);
        vic_pkg::color_t c;
        vic_pkg::color_t own;
        logic [1:0]      p;
        c = base;
        for (int s = vic_pkg::NUM_SPRITES - 1; s >= 0; s--) begin
            p   = pix[2*(vic_pkg::NUM_SPRITES-1-s) +: 2];
            own = sprite_colors_i[4*(vic_pkg::NUM_SPRITES-1-s) +: 4];
            if (sprite_pri_i[s] && !bg) begin
                // behind foreground, hides whatever lower sprites drew
                if (p[1]) begin
                    c = base;
                end
            end else if (sprite_mmc_i[s]) begin
                case (p)
                    2'b01:   c = sprite_mc0_i;
                    2'b10:   c = own;
                    2'b11:   c = sprite_mc1_i;
                    default: c = c;
                endcase
            end else if (p[1]) begin
                c = own;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_o          <= '0;
            running          <= 1'b0;
            line_cycle       <= '0;
            fetch_byte       <= '0;
            fetch_code       <= '0;
            fine_x           <= '0;
            sr               <= '0;
            sr_code          <= '0;
            sr_mc            <= 1'b0;
            sr_odd           <= 1'b0;
            exp_background_o <= 1'b1;
            s1_color         <= vic_pkg::COLOR_BLACK;
            s1_bg            <= 1'b1;
            s1_spr           <= '0;
            s2_color         <= vic_pkg::COLOR_BLACK;
            exp_color_o      <= vic_pkg::COLOR_BLACK;
        end else begin
            running <= 1'b1;
            phase_o <= (phase_o == 5'(vic_pkg::PHASES_PER_CYCLE - 1)) ? 5'd0 : phase_o + 5'd1;
            if (phase_o == 5'(vic_pkg::PHASES_PER_CYCLE - 1)) begin
                line_cycle <= (int'(line_cycle) == vic_pkg::CYCLES_PER_LINE - 1) ?
                              '0 : line_cycle + 7'd1;
            end
            if (phase_o == 5'(vic_pkg::PIXEL_LATCH_PHASE)) begin
                fetch_byte <= pixels_read_i;
                fetch_code <= char_read_i;
            end
            if (phase_o == 5'(vic_pkg::XSCROLL_PHASE) && in_window) begin
                fine_x <= xscroll_i;
            end
            if (dot_now) begin
                s1_color <= decode_color(sr[7:6], sr_code);
                s1_bg    <= exp_background_o;
                s1_spr   <= sprite_pixels_i;
                if (phase_o[4:2] == fine_x) begin
                    sr               <= fetch_byte;
                    sr_code          <= fetch_code;
                    // pairs in bitmap or ecm, char mode needs colour nibble bit 3
                    sr_mc            <= mcm_i && (bmm_i || ecm_i || fetch_code[11]);
                    sr_odd           <= 1'b0;
                    exp_background_o <= !fetch_byte[7];
                end else begin
                    if (sr_mc && sr_odd) begin
                        sr               <= sr << 2;
                        exp_background_o <= !sr[5];
                    end else if (!sr_mc) begin
                        sr               <= sr << 1;
                        exp_background_o <= !sr[6];
                    end
                    sr_odd <= !sr_odd;
                end
            end
            s2_color    <= overlay(invalid ? vic_pkg::COLOR_BLACK : s1_color, s1_bg, s1_spr);
            exp_color_o <= main_border_i ? ec_i : s2_color;
        end
    end

endmodule

/* verification/pixel_path_tb.sv */
`timescale 1ns/1ps

module pixel_path_tb;

    localparam int          LINE_CLOCKS = vic_pkg::CYCLES_PER_LINE * vic_pkg::PHASES_PER_CYCLE;
    localparam int          NUM_TESTS   = 6;
    localparam int          CYCLE_LIMIT = NUM_TESTS * LINE_CLOCKS * 11 / 10;
    localparam logic [31:0] SEED        = 32'h4518_2390;

    logic                clk_dot4x;
    logic                rst;
    vic_pkg::gfx_byte_t  pixels_read_i;
    vic_pkg::char_code_t char_read_i;
    vic_pkg::xscroll_t   xscroll_i;
    logic                ecm_i;
    logic                bmm_i;
    logic                mcm_i;
    vic_pkg::color_t     b0c_i;
    vic_pkg::color_t     b1c_i;
    vic_pkg::color_t     b2c_i;
    vic_pkg::color_t     b3c_i;
    vic_pkg::color_t     ec_i;
    logic                main_border_i;
    logic [15:0]         sprite_pixels_i;
    logic [31:0]         sprite_colors_i;
    logic [7:0]          sprite_pri_i;
    logic [7:0]          sprite_mmc_i;
    vic_pkg::color_t     sprite_mc0_i;
    vic_pkg::color_t     sprite_mc1_i;
    vic_pkg::color_t     dut_color;
    logic                dut_background;
    logic [4:0]          model_phase;
    vic_pkg::color_t     exp_color;
    logic                exp_background;

    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  test_errors;
    int                  test_checks;
    int                  cycle_count;
    logic                use_sprites;
    logic                use_border;
    vic_pkg::xscroll_t   scroll_pick;
    vic_pkg::vic_mode_e  mode_pool[$];

    tb_clock clock_i (.clk_o(clk_dot4x));

    pixel_path_top dut_i (
        .*,
        .pixel_color_o   (dut_color),
        .is_background_o (dut_background)
    );

    pixel_ref_model model_i (
        .*,
        .phase_o          (model_phase),
        .exp_color_o      (exp_color),
        .exp_background_o (exp_background)
    );

    task automatic check_color(string sig, vic_pkg::color_t got, vic_pkg::color_t want);
        checks++;
        test_checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("Fail %s got %h expected %h at %0t", sig, got, want, $time);
        end
    endtask

    task automatic check_background(string sig, logic got, logic want);
        checks++;
        test_checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("Fail %s got %h expected %h at %0t", sig, got, want, $time);
        end
    endtask

    task automatic start_test(logic sprites, logic border);
        test_errors = 0;
        test_checks = 0;
        use_sprites = sprites;
        use_border  = border;
        scroll_pick = vic_pkg::xscroll_t'($urandom);
        mode_pool.delete();
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: %0d checks ok", tests_run, name, test_checks);
        end else begin
            $display("test %0d %s: %0d of %0d checks wrong", tests_run, name,
                     test_errors, test_checks);
        end
    endtask

    // new values land in the clock right after a dot strobe edge
    task automatic drive_inputs();
        vic_pkg::vic_mode_e pick;
        if (model_phase == 5'd1) begin
            xscroll_i     = scroll_pick;
            pixels_read_i = vic_pkg::gfx_byte_t'($urandom);
            char_read_i   = vic_pkg::char_code_t'($urandom);
            pick          = mode_pool[$urandom_range(mode_pool.size() - 1)];
            {ecm_i, bmm_i, mcm_i} = pick;
            b0c_i = vic_pkg::color_t'($urandom);
            b1c_i = vic_pkg::color_t'($urandom);
            b2c_i = vic_pkg::color_t'($urandom);
            b3c_i = vic_pkg::color_t'($urandom);
            ec_i  = vic_pkg::color_t'($urandom);
            if (use_sprites) begin
                sprite_colors_i = $urandom;
                sprite_pri_i    = 8'($urandom);
                sprite_mmc_i    = 8'($urandom);
                sprite_mc0_i    = vic_pkg::color_t'($urandom);
                sprite_mc1_i    = vic_pkg::color_t'($urandom);
            end
        end
        if (model_phase[1:0] == 2'b01) begin
            if (use_sprites) begin
                sprite_pixels_i = 16'($urandom);
            end else begin
                sprite_pixels_i = '0;
            end
            if (use_border) begin
                main_border_i = ($urandom_range(3) == 0);
            end else begin
                main_border_i = 1'b0;
            end
        end
    endtask

    // one clock, compared in the last clock of each dot
    task automatic step_clock();
        @(posedge clk_dot4x);
        #1;
        drive_inputs();
        @(negedge clk_dot4x);
        if (model_phase[1:0] == 2'b11) begin
            check_color("pixel_color_o", dut_color, exp_color);
            check_background("is_background_o", dut_background, exp_background);
        end
    endtask

    task automatic run_line(string name);
        repeat (LINE_CLOCKS) step_clock();
        end_test(name);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_dot4x);
            cycle_count++;
        end
        $display("run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        void'($urandom(SEED));
        rst             = 1'b1;
        // only b0c is black, every other colour source and the fetch data are not
        pixels_read_i   = 8'hff;
        char_read_i     = 12'hfff;
        xscroll_i       = 3'd5;
        ecm_i           = 1'b0;
        bmm_i           = 1'b0;
        mcm_i           = 1'b0;
        b0c_i           = '0;
        b1c_i           = 4'h1;
        b2c_i           = 4'h2;
        b3c_i           = 4'h3;
        ec_i            = 4'he;
        main_border_i   = 1'b0;
        sprite_pixels_i = '0;
        sprite_colors_i = 32'h1234_5678;
        sprite_pri_i    = '0;
        sprite_mmc_i    = '0;
        sprite_mc0_i    = 4'ha;
        sprite_mc1_i    = 4'hb;
        use_sprites     = 1'b0;
        use_border      = 1'b0;
        scroll_pick     = '0;
        repeat (5) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;

        // first load comes at dot 0 of the next bus cycle
        test_errors = 0;
        test_checks = 0;
        repeat (24) begin
            @(negedge clk_dot4x);
            check_color("pixel_color_o", dut_color, vic_pkg::COLOR_BLACK);
            check_background("is_background_o", dut_background, 1'b1);
        end
        end_test("reset state");

        start_test(1'b0, 1'b0);
        mode_pool.push_back(vic_pkg::mode_std_char);
        mode_pool.push_back(vic_pkg::mode_std_bmp);
        run_line("standard char and bitmap");

        start_test(1'b0, 1'b0);
        mode_pool.push_back(vic_pkg::mode_mc_char);
        mode_pool.push_back(vic_pkg::mode_mc_bmp);
        run_line("multicolour char and bitmap");

        start_test(1'b0, 1'b0);
        mode_pool.push_back(vic_pkg::mode_ecm_char);
        mode_pool.push_back(vic_pkg::mode_inv_ecm_mc_char);
        mode_pool.push_back(vic_pkg::mode_inv_ecm_bmp);
        mode_pool.push_back(vic_pkg::mode_inv_ecm_mc_bmp);
        run_line("extended background and invalid modes");

        start_test(1'b1, 1'b0);
        for (int m = 0; m < 5; m++) begin
            mode_pool.push_back(vic_pkg::vic_mode_e'(m));
        end
        run_line("sprite overlay");

        start_test(1'b1, 1'b1);
        for (int m = 0; m < 8; m++) begin
            mode_pool.push_back(vic_pkg::vic_mode_e'(m));
        end
        run_line("border mask");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
src/vic_pkg.sv
src/dot_timing.sv
src/gfx_latch.sv
src/pixel_shifter.sv
src/color_mixer.sv
src/pixel_path_top.sv
verification/tb_clock.sv
verification/pixel_ref_model.sv
verification/pixel_path_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pixel_path_tb -f files.f -Mdir obj_dir -o pixel_path_sim

./obj_dir/pixel_path_sim | tee sim.log

if grep -qx -- '>>> PASS' sim.log; then
    exit 0
else
    echo "simulation did not report a pass, see sim.log"
    exit 1
fi
